// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module renameCoreTb -f vlog.f \
    --Mdir obj_dir -o renameCoreTb

# A run that stops early still leaves its log for the check below
./obj_dir/renameCoreTb > sim.log 2>&1 || true
cat sim.log

grep -q "^All checks passed$" sim.log

// File: verification/renameCoreTb.sv
`timescale 1ns/1ns
module renameCoreTb;
    import frontPkg::*;

    localparam int NUM_QUEUES    = 3;
    localparam int QUEUE_DEPTH   = 4;
    localparam int ISSUE_CREDITS = 2;
    localparam int NUM_INSTR     = 400;
    localparam int CLK_PERIOD    = 10;
    localparam int WATCHDOG_NS   = NUM_INSTR * 20 * CLK_PERIOD;

    logic     clk = 1'b0;
    logic     rstN;
    logic     instrValid;
    logic [31:0] instr;
    logic     instrCredit;
    logic     issueValid;
    renamedOp issueOp;
    logic     issueCredit;
    logic     wakeValid;
    physTag   wakeTag;
    logic     relValid;
    physTag   relTag;

    logic [31:0] lcgState = 32'hd7ca;
    int          cycle;
    int          valueErrors;
    int          flowErrors;

    // Reference model state
    physTag          mapModel [ARCH_REGS];
    physTag          freeQ [$];
    logic [PHYS_TAGS-1:0] readyModel;

    // Per-instruction bookkeeping by send order
    logic [31:0] words [NUM_INSTR];
    renamedOp    pred [NUM_INSTR];
    bit          issued [NUM_INSTR];
    bit          woken [NUM_INSTR];
    int          sentCnt;
    int          predCnt;     // Ops already run through the model
    int          retirePtr;   // Oldest op not yet retired
    int          instrOut;    // Words sent without a credit back
    int          issueOut;    // Issued ops without a credit back

    // Pending wakeups in issue order
    physTag wakeTagQ [$];
    int     wakeDueQ [$];
    int     wakeIdxQ [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    renameCore #(
        .NUM_QUEUES   (NUM_QUEUES),
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .ISSUE_CREDITS(ISSUE_CREDITS)
    ) u_renameCore (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrCredit(instrCredit),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueCredit(issueCredit),
        .wakeValid  (wakeValid),
        .wakeTag    (wakeTag),
        .relValid   (relValid),
        .relTag     (relTag)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Sign extends the top bits of a left-aligned field
    function automatic logic [31:0] signExtend(input logic [31:0] left, input int bits);
        return $signed(left) >>> (32 - bits);
    endfunction

    // Random RV32I word on x0-x7 so that ops depend on each other
    function automatic logic [31:0] makeWord();
        logic [31:0] r;
        logic [31:0] w;
        logic [6:0]  opc;
        r = nextRand();
        w = nextRand();
        case (r[27:24])
            4'd0, 4'd1, 4'd2: opc = 7'b0110011;
            4'd3, 4'd4: opc = 7'b0010011;
            4'd5, 4'd12: opc = 7'b0000011;
            4'd6: opc = 7'b0100011;
            4'd7: opc = 7'b1100011;
            4'd8: opc = 7'b1101111;
            4'd9: opc = 7'b1100111;
            4'd10: opc = 7'b0110111;
            4'd11: opc = 7'b0010111;
            default: opc = r[21] ? 7'b1111111 : 7'b0001011;   // Not in RV32I
        endcase
        w[6:0] = opc;
        w[11:7] = {2'b00, r[14:12]};
        w[19:15] = {2'b00, r[17:15]};
        w[24:20] = {2'b00, r[20:18]};
        return w;
    endfunction

    // Expected renamed op without the ready flags
    function automatic renamedOp predictRename(input logic [31:0] w, input logic [7:0] seq);
        renamedOp p;
        logic     s1Use;
        logic     s2Use;
        logic     rdUse;
        p = '0;
        p.funct3 = w[14:12];
        p.funct7 = w[31:25];
        p.seqNum = seq;
        s1Use = 1'b0;
        s2Use = 1'b0;
        rdUse = 1'b0;
        case (w[6:0])
            7'h33: begin
                p.cls = classAlu;
                s1Use = 1'b1;
                s2Use = 1'b1;
                rdUse = 1'b1;
            end
            7'h13, 7'h03: begin
                p.cls = (w[6:0] == 7'h13) ? classAluImm : classLoad;
                s1Use = 1'b1;
                rdUse = 1'b1;
                p.imm = signExtend(w, 12);
            end
            7'h23: begin
                p.cls = classStore;
                s1Use = 1'b1;
                s2Use = 1'b1;
                p.imm = signExtend({w[31:25], w[11:7], 20'h0}, 12);
            end
            7'h63: begin
                p.cls = classBranch;
                s1Use = 1'b1;
                s2Use = 1'b1;
                p.imm = signExtend({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'h0}, 13);
            end
            7'h6f: begin   // JAL
                p.cls = classBranch;
                rdUse = 1'b1;
                p.imm = signExtend({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'h0}, 21);
            end
            7'h67: begin   // JALR
                p.cls = classBranch;
                s1Use = 1'b1;
                rdUse = 1'b1;
                p.imm = signExtend(w, 12);
            end
            7'h37, 7'h17: begin
                p.cls = classLui;
                rdUse = 1'b1;
                p.imm = {w[31:12], 12'h0};
            end
            default: p.cls = classIllegal;
        endcase
        if (s1Use) p.src1Tag = mapModel[w[19:15]];
        if (s2Use) p.src2Tag = mapModel[w[24:20]];
        if (rdUse && w[11:7] != 5'd0) begin
            p.writesRd = 1'b1;
            p.oldDestTag = mapModel[w[11:7]];
            if (freeQ.size() == 0) begin
                $display("Model free list is empty when op %0d needs a tag", seq);
                flowErrors++;
            end else begin
                p.destTag = freeQ.pop_front();
                mapModel[w[11:7]] = p.destTag;
                readyModel[p.destTag] = 1'b0;   // Busy until its wakeup
            end
        end
        return p;
    endfunction

    // Unissued ops all lie within 256 of the oldest unretired one
    function automatic int fullIndex(input logic [7:0] seq);
        logic [7:0] offset;
        offset = seq - retirePtr[7:0];
        return retirePtr + int'(offset);
    endfunction

    task automatic checkTag(input string name, input physTag got, input physTag exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkClass(input string name, input opClass got, input opClass exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            valueErrors++;
        end
    endtask

    task automatic checkImm(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkField(input string name, input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic compareOp(input renamedOp got, input renamedOp exp);
        checkClass("issueOp.cls", got.cls, exp.cls);
        checkField("issueOp.funct3", 7'(got.funct3), 7'(exp.funct3));
        checkField("issueOp.funct7", got.funct7, exp.funct7);
        checkField("issueOp.writesRd", 7'(got.writesRd), 7'(exp.writesRd));
        checkImm("issueOp.imm", got.imm, exp.imm);
        checkTag("issueOp.src1Tag", got.src1Tag, exp.src1Tag);
        checkTag("issueOp.src2Tag", got.src2Tag, exp.src2Tag);
        checkTag("issueOp.destTag", got.destTag, exp.destTag);
        checkTag("issueOp.oldDestTag", got.oldDestTag, exp.oldDestTag);
        // Only ops with both sources ready may leave a queue
        checkField("issueOp.src1Ready", 7'(got.src1Ready), 7'd1);
        checkField("issueOp.src2Ready", 7'(got.src2Ready), 7'd1);
    endtask

    // Checks each issued op against the model
    always @(posedge clk) begin
        int idx;
        if (rstN && issueValid) begin
            idx = fullIndex(issueOp.seqNum);
            if (idx >= sentCnt) begin
                $display("Op with seqNum %0d issued but never sent", issueOp.seqNum);
                flowErrors++;
            end else if (issued[idx]) begin
                $display("Op with seqNum %0d issued a second time", issueOp.seqNum);
                flowErrors++;
            end else begin
                while (predCnt <= idx) begin   // Model runs in program order
                    pred[predCnt] = predictRename(words[predCnt], predCnt[7:0]);
                    predCnt++;
                end
                issued[idx] = 1'b1;
                compareOp(issueOp, pred[idx]);
                if (!readyModel[pred[idx].src1Tag] || !readyModel[pred[idx].src2Tag]) begin
                    $display("Op %0d issued before its source tags were ready", idx);
                    flowErrors++;
                end
                issueOut++;
                if (issueOut > ISSUE_CREDITS) begin
                    $display("More issued ops outstanding than issue credits at %0t", $time);
                    flowErrors++;
                end
                if (pred[idx].writesRd) begin
                    wakeTagQ.push_back(pred[idx].destTag);
                    wakeDueQ.push_back(cycle + int'(nextRand() >> 30));   // 0 to 3 cycles
                    wakeIdxQ.push_back(idx);
                end
            end
        end
    end

    task trackInstrCredit();
        if (instrCredit) begin
            if (instrOut == 0) begin
                $display("Instruction credit returned with nothing outstanding at %0t", $time);
                flowErrors++;
            end else begin
                instrOut--;
            end
        end
    endtask

    task sendWord();
        logic [31:0] w;
        w = makeWord();
        instr = w;
        instrValid = 1'b1;
        words[sentCnt] = w;
        sentCnt++;
        instrOut++;
    endtask

    task deliverWake();
        int idx;
        if (wakeTagQ.size() != 0 && cycle >= wakeDueQ[0]) begin
            wakeValid = 1'b1;
            wakeTag = wakeTagQ.pop_front();
            idx = wakeIdxQ.pop_front();
            wakeDueQ.delete(0);
            woken[idx] = 1'b1;
            readyModel[wakeTag] = 1'b1;
        end
    endtask

    // In-order retire releases the old destination
    task retireOldest();
        if (retirePtr < sentCnt && issued[retirePtr] &&
            (woken[retirePtr] || !pred[retirePtr].writesRd)) begin
            if (pred[retirePtr].writesRd) begin
                relValid = 1'b1;
                relTag = pred[retirePtr].oldDestTag;
                freeQ.push_back(relTag);
            end
            retirePtr++;
        end
    endtask

    initial begin
        logic [31:0] r;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        issueCredit = 1'b0;
        wakeValid = 1'b0;
        wakeTag = '0;
        relValid = 1'b0;
        relTag = '0;
        readyModel = '1;
        for (int i = 0; i < ARCH_REGS; i++) begin
            mapModel[i] = physTag'(i);
        end
        for (int i = ARCH_REGS; i < PHYS_TAGS; i++) begin
            freeQ.push_back(physTag'(i));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (retirePtr < NUM_INSTR) begin
            @(negedge clk);
            cycle++;
            r = nextRand();
            instrValid = 1'b0;
            issueCredit = 1'b0;
            wakeValid = 1'b0;
            relValid = 1'b0;
            trackInstrCredit();
            if (sentCnt < NUM_INSTR && instrOut < 2 && r[18:16] != 3'd0) begin
                sendWord();
            end
            if (issueOut > 0 && r[21]) begin   // Output side returns credits at random
                issueCredit = 1'b1;
                issueOut--;
            end
            deliverWake();
            retireOldest();
        end
        @(negedge clk);
        instrValid = 1'b0;
        issueCredit = 1'b0;
        wakeValid = 1'b0;
        relValid = 1'b0;
        repeat (10) @(negedge clk);   // Room for a stray issue to show up
        if (instrOut != 0) begin
            $display("Decoder still holds %0d instruction credits at the end", instrOut);
            flowErrors++;
        end
        $display("Error counts: value %0d, flow %0d", valueErrors, flowErrors);
        if (valueErrors == 0 && flowErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: %0d of %0d ops retired", retirePtr, NUM_INSTR);
        $display("Error counts: value %0d, flow %0d", valueErrors, flowErrors + 1);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: verilog/dispatchRouter.sv
`timescale 1ns/1ns
module dispatchRouter #(
    parameter int NUM_QUEUES  = 3,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  renValid,
    input  frontPkg::renamedOp    renOp,
    output logic                  renCredit,
    input  logic                  wakeValid,
    input  frontPkg::physTag      wakeTag,
    output logic [NUM_QUEUES-1:0] qValid,
    output frontPkg::renamedOp    qOp,
    input  logic [NUM_QUEUES-1:0] qCredit
);
    import frontPkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int SEL_W = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

    renamedOp         heldOp;
    logic             heldValid;
    logic [CNT_W-1:0] credCnt [NUM_QUEUES];
    logic [SEL_W-1:0] sel;

    // Most credits wins, lowest index on a tie
    always_comb begin
        sel = '0;
        for (int i = 1; i < NUM_QUEUES; i++) begin
            if (credCnt[i] > credCnt[sel]) begin
                sel = SEL_W'(i);
            end
        end
    end

    always_comb begin
        qValid = '0;
        if (heldValid && credCnt[sel] != '0) begin
            qValid[sel] = 1'b1;
        end
    end

    assign renCredit = |qValid;
    assign qOp = heldOp;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldValid <= 1'b0;
            for (int i = 0; i < NUM_QUEUES; i++) begin
                credCnt[i] <= CNT_W'(QUEUE_DEPTH);
            end
        end else begin
            heldValid <= (heldValid && !renCredit) || renValid;
            for (int i = 0; i < NUM_QUEUES; i++) begin
                credCnt[i] <= credCnt[i] - CNT_W'(qValid[i]) + CNT_W'(qCredit[i]);
            end
        end
    end

    // A waiting op still picks up wakeups
    always_ff @(posedge clk) begin
        if (renValid) begin
            heldOp <= renOp;
        end else if (wakeValid) begin
            if (heldOp.src1Tag == wakeTag) begin
                heldOp.src1Ready <= 1'b1;
            end
            if (heldOp.src2Tag == wakeTag) begin
                heldOp.src2Ready <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/frontPkg.sv
package frontPkg;

    localparam int PHYS_TAGS = 64;
    localparam int ARCH_REGS = 32;
    localparam int TAG_W = $clog2(PHYS_TAGS);

    typedef logic [TAG_W-1:0] physTag;
    typedef logic [4:0] archReg;

    typedef enum logic [2:0] {
        classAlu,
        classAluImm,
        classLoad,
        classStore,
        classBranch,   // Conditional branches, JAL and JALR
        classLui,      // LUI and AUIPC
        classIllegal
    } opClass;

    // Decoder output, one RV32I instruction
    typedef struct packed {
        opClass     cls;
        logic [2:0] funct3;
        logic [6:0] funct7;
        archReg     rs1;
        archReg     rs2;
        archReg     rd;
        logic       useRs1;
        logic       useRs2;
        logic       writesRd;   // Never set for rd = x0
        logic [31:0] imm;
        logic [7:0] seqNum;
    } decodedOp;

    // Rename output, carried through the issue queues
    typedef struct packed {
        opClass     cls;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [31:0] imm;
        physTag     src1Tag;
        physTag     src2Tag;
        physTag     destTag;
        physTag     oldDestTag;   // Previous mapping of rd, freed at retire
        logic       src1Ready;
        logic       src2Ready;
        logic       writesRd;
        logic [7:0] seqNum;
    } renamedOp;

endpackage

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns
module instrDecoder (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic [31:0]        instr,
    output logic               instrCredit,
    output logic               decValid,
    output frontPkg::decodedOp decOp,
    input  logic               decCredit
);
    import frontPkg::*;

    decodedOp   bufOp [2];
    logic       wrPtr;
    logic       rdPtr;
    logic [1:0] bufCnt;
    logic [1:0] credCnt;   // Credits toward rename
    logic [7:0] seqCnt;

    function automatic decodedOp decode(input logic [31:0] w, input logic [7:0] seq);
        decodedOp d;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immU = {w[31:12], 12'b0};
        immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        d = '0;
        d.funct3 = w[14:12];
        d.funct7 = w[31:25];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.rd = w[11:7];
        d.seqNum = seq;
        // Flags below are {useRs1, useRs2, writesRd}
        case (w[6:0])
            7'b0110011: begin
                d.cls = classAlu;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b111;
            end
            7'b0010011: begin
                d.cls = classAluImm;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b101;
                d.imm = immI;
            end
            7'b0000011: begin
                d.cls = classLoad;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b101;
                d.imm = immI;
            end
            7'b0100011: begin
                d.cls = classStore;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b110;
                d.imm = immS;
            end
            7'b1100011: begin
                d.cls = classBranch;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b110;
                d.imm = immB;
            end
            7'b1101111: begin   // JAL links into rd
                d.cls = classBranch;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b001;
                d.imm = immJ;
            end
            7'b1100111: begin   // JALR
                d.cls = classBranch;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b101;
                d.imm = immI;
            end
            7'b0110111, 7'b0010111: begin
                d.cls = classLui;
                {d.useRs1, d.useRs2, d.writesRd} = 3'b001;
                d.imm = immU;
            end
            default: d.cls = classIllegal;   // No register use at all
        endcase
        d.writesRd = d.writesRd && (w[11:7] != 5'd0);
        return d;
    endfunction

    assign decValid = (bufCnt != 2'd0) && (credCnt != 2'd0);
    assign decOp = bufOp[rdPtr];
    assign instrCredit = decValid;   // Entry leaves the buffer

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            bufCnt <= 2'd0;
            credCnt <= 2'd1;
            seqCnt <= 8'd0;
        end else begin
            if (instrValid) begin
                wrPtr <= ~wrPtr;
                seqCnt <= seqCnt + 8'd1;
            end
            if (decValid) begin
                rdPtr <= ~rdPtr;
            end
            bufCnt <= bufCnt + 2'(instrValid) - 2'(decValid);
            credCnt <= credCnt - 2'(decValid) + 2'(decCredit);
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            bufOp[wrPtr] <= decode(instr, seqCnt);   // Decode on entry
        end
    end

    // Rename hands back no more credits than it was sent
    assert property (@(posedge clk) disable iff (!rstN) credCnt <= 2'd1)
        else $error("instrDecoder: credit counter out of range");

endmodule

// File: verilog/issueQueue.sv
`timescale 1ns/1ns
module issueQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,
    input  frontPkg::renamedOp inOp,
    input  logic               wakeValid,
    input  frontPkg::physTag   wakeTag,
    output logic               offerValid,
    output frontPkg::renamedOp offerOp,
    input  logic               grant,
    output logic               qCredit
);
    import frontPkg::*;

    localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    renamedOp         entryOp [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] entryValid;
    logic [IDX_W-1:0] entryAge [QUEUE_DEPTH];   // Rank among valid entries, 0 is youngest
    logic [IDX_W-1:0] offerIdx;
    logic [IDX_W-1:0] freeIdx;
    logic             removing;
    logic             full;

    // Oldest entry with both sources ready
    always_comb begin
        offerValid = 1'b0;
        offerIdx = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (entryValid[i] && entryOp[i].src1Ready && entryOp[i].src2Ready &&
                (!offerValid || entryAge[i] > entryAge[offerIdx])) begin
                offerValid = 1'b1;
                offerIdx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        freeIdx = '0;
        for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                freeIdx = IDX_W'(i);
            end
        end
    end

    assign full = &entryValid;
    assign offerOp = entryOp[offerIdx];
    assign removing = offerValid && grant;
    assign qCredit = removing;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entryAge[i] <= '0;
            end
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (entryValid[i] && !(removing && offerIdx == IDX_W'(i))) begin
                    entryAge[i] <= entryAge[i] + IDX_W'(inValid)
                        - IDX_W'(removing && entryAge[i] > entryAge[offerIdx]);
                end
            end
            if (removing) begin
                entryValid[offerIdx] <= 1'b0;
            end
            if (inValid) begin
                entryValid[freeIdx] <= 1'b1;
                entryAge[freeIdx] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (wakeValid && entryOp[i].src1Tag == wakeTag) begin
                entryOp[i].src1Ready <= 1'b1;
            end
            if (wakeValid && entryOp[i].src2Tag == wakeTag) begin
                entryOp[i].src2Ready <= 1'b1;
            end
        end
        if (inValid) begin
            entryOp[freeIdx] <= inOp;
            if (wakeValid && inOp.src1Tag == wakeTag) begin
                entryOp[freeIdx].src1Ready <= 1'b1;   // Same-cycle wakeup on write
            end
            if (wakeValid && inOp.src2Tag == wakeTag) begin
                entryOp[freeIdx].src2Ready <= 1'b1;
            end
        end
    end

    // Router credits keep a full queue from being written
    assert property (@(posedge clk) disable iff (!rstN) inValid |-> !full)
        else $error("issueQueue: op received while full");

endmodule

// File: verilog/issueSelect.sv
`timescale 1ns/1ns
module issueSelect #(
    parameter int NUM_QUEUES    = 3,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [NUM_QUEUES-1:0] offerValid,
    input  frontPkg::renamedOp    offerOp [NUM_QUEUES],
    output logic [NUM_QUEUES-1:0] grant,
    output logic                  issueValid,
    output frontPkg::renamedOp    issueOp,
    input  logic                  issueCredit
);
    import frontPkg::*;

    localparam int SEL_W = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int CNT_W = $clog2(ISSUE_CREDITS + 1);

    logic [SEL_W-1:0] lastGrant;
    logic [SEL_W-1:0] pick;
    logic [CNT_W-1:0] credCnt;
    logic             found;

    always_comb begin
        int idx;
        found = 1'b0;
        pick = '0;
        grant = '0;
        // Search starts just after the last granted queue
        for (int k = 1; k <= NUM_QUEUES; k++) begin
            idx = (int'(lastGrant) + k) % NUM_QUEUES;
            if (!found && offerValid[idx]) begin
                found = 1'b1;
                pick = SEL_W'(idx);
            end
        end
        if (credCnt != '0) begin
            grant[pick] = found;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastGrant <= SEL_W'(NUM_QUEUES - 1);   // Queue 0 goes first
            credCnt <= CNT_W'(ISSUE_CREDITS);
            issueValid <= 1'b0;
        end else begin
            issueValid <= |grant;
            credCnt <= credCnt - CNT_W'(|grant) + CNT_W'(issueCredit);
            if (|grant) begin
                lastGrant <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            issueOp <= offerOp[pick];
        end
    end

endmodule

// File: verilog/renameCore.sv
`timescale 1ns/1ns
module renameCore #(
    parameter int NUM_QUEUES    = 3,
    parameter int QUEUE_DEPTH   = 4,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic [31:0]        instr,
    output logic               instrCredit,
    output logic               issueValid,
    output frontPkg::renamedOp issueOp,
    input  logic               issueCredit,
    input  logic               wakeValid,
    input  frontPkg::physTag   wakeTag,
    input  logic               relValid,
    input  frontPkg::physTag   relTag
);
    import frontPkg::*;

    logic                  decValid;
    logic                  decCredit;
    decodedOp              decOp;
    logic                  renValid;
    logic                  renCredit;
    renamedOp              renOp;
    logic [NUM_QUEUES-1:0] qValid;
    logic [NUM_QUEUES-1:0] qCredit;
    renamedOp              qOp;
    logic [NUM_QUEUES-1:0] offerValid;
    logic [NUM_QUEUES-1:0] grant;
    renamedOp              offerOp [NUM_QUEUES];

    instrDecoder u_instrDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrCredit(instrCredit),
        .decValid   (decValid),
        .decOp      (decOp),
        .decCredit  (decCredit)
    );

    renameUnit u_renameUnit (
        .clk       (clk),
        .rstN      (rstN),
        .decValid  (decValid),
        .decOp     (decOp),
        .decCredit (decCredit),
        .renValid  (renValid),
        .renOp     (renOp),
        .renCredit (renCredit),
        .wakeValid (wakeValid),
        .wakeTag   (wakeTag),
        .relValid  (relValid),
        .relTag    (relTag)
    );

    dispatchRouter #(
        .NUM_QUEUES (NUM_QUEUES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_dispatchRouter (
        .clk      (clk),
        .rstN     (rstN),
        .renValid (renValid),
        .renOp    (renOp),
        .renCredit(renCredit),
        .wakeValid(wakeValid),
        .wakeTag  (wakeTag),
        .qValid   (qValid),
        .qOp      (qOp),
        .qCredit  (qCredit)
    );

    // All queues see the same op bus, qValid picks one
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        issueQueue #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_issueQueue (
            .clk       (clk),
            .rstN      (rstN),
            .inValid   (qValid[q]),
            .inOp      (qOp),
            .wakeValid (wakeValid),
            .wakeTag   (wakeTag),
            .offerValid(offerValid[q]),
            .offerOp   (offerOp[q]),
            .grant     (grant[q]),
            .qCredit   (qCredit[q])
        );
    end

    issueSelect #(
        .NUM_QUEUES   (NUM_QUEUES),
        .ISSUE_CREDITS(ISSUE_CREDITS)
    ) u_issueSelect (
        .clk        (clk),
        .rstN       (rstN),
        .offerValid (offerValid),
        .offerOp    (offerOp),
        .grant      (grant),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueCredit(issueCredit)
    );

endmodule

// File: verilog/renameUnit.sv
`timescale 1ns/1ns
module renameUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               decValid,
    input  frontPkg::decodedOp decOp,
    output logic               decCredit,
    output logic               renValid,
    output frontPkg::renamedOp renOp,
    input  logic               renCredit,
    input  logic               wakeValid,
    input  frontPkg::physTag   wakeTag,
    input  logic               relValid,
    input  frontPkg::physTag   relTag
);
    import frontPkg::*;

    localparam int FREE_N = PHYS_TAGS - ARCH_REGS;
    localparam int PTR_W = $clog2(FREE_N);

    decodedOp             inOp;
    logic                 inValid;
    logic                 credOk;   // Single credit toward the router
    physTag               mapTable [ARCH_REGS];
    physTag               freeList [FREE_N];
    logic [PTR_W-1:0]     freeHead;
    logic [PTR_W-1:0]     freeTail;
    logic [PTR_W:0]       freeCnt;
    logic [PHYS_TAGS-1:0] readyBits;
    logic                 fire;
    logic                 popTag;
    physTag               src1Tag;
    physTag               src2Tag;

    // Unused sources read x0, which stays on tag 0
    assign src1Tag = inOp.useRs1 ? mapTable[inOp.rs1] : '0;
    assign src2Tag = inOp.useRs2 ? mapTable[inOp.rs2] : '0;

    assign fire = inValid && credOk && (!inOp.writesRd || freeCnt != '0);
    assign popTag = fire && inOp.writesRd;
    assign renValid = fire;
    assign decCredit = fire;

    always_comb begin
        renOp = '0;
        renOp.cls = inOp.cls;
        renOp.funct3 = inOp.funct3;
        renOp.funct7 = inOp.funct7;
        renOp.imm = inOp.imm;
        renOp.src1Tag = src1Tag;
        renOp.src2Tag = src2Tag;
        renOp.src1Ready = readyBits[src1Tag] || (wakeValid && wakeTag == src1Tag);
        renOp.src2Ready = readyBits[src2Tag] || (wakeValid && wakeTag == src2Tag);
        renOp.writesRd = inOp.writesRd;
        renOp.seqNum = inOp.seqNum;
        if (inOp.writesRd) begin
            renOp.destTag = freeList[freeHead];
            renOp.oldDestTag = mapTable[inOp.rd];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inValid <= 1'b0;
            credOk <= 1'b1;
            freeHead <= '0;
            freeTail <= '0;
            freeCnt <= (PTR_W+1)'(FREE_N);
            readyBits <= '1;
            for (int i = 0; i < ARCH_REGS; i++) begin
                mapTable[i] <= physTag'(i);   // Identity map
            end
            for (int i = 0; i < FREE_N; i++) begin
                freeList[i] <= physTag'(ARCH_REGS + i);
            end
        end else begin
            inValid <= (inValid && !fire) || decValid;
            credOk <= (credOk && !fire) || renCredit;
            if (wakeValid) begin
                readyBits[wakeTag] <= 1'b1;
            end
            if (popTag) begin
                readyBits[renOp.destTag] <= 1'b0;
                mapTable[inOp.rd] <= renOp.destTag;
                freeHead <= freeHead + 1'b1;
            end
            if (relValid) begin
                freeList[freeTail] <= relTag;
                freeTail <= freeTail + 1'b1;
            end
            freeCnt <= freeCnt + (PTR_W+1)'(relValid) - (PTR_W+1)'(popTag);
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            inOp <= decOp;
        end
    end

    // Only retired old destinations come back, so the list cannot overflow
    assert property (@(posedge clk) disable iff (!rstN) relValid |-> freeCnt != FREE_N)
        else $error("renameUnit: tag released into a full free list");

endmodule

// File: vlog.f
verilog/frontPkg.sv
verilog/instrDecoder.sv
verilog/renameUnit.sv
verilog/dispatchRouter.sv
verilog/issueQueue.sv
verilog/issueSelect.sv
verilog/renameCore.sv
verification/renameCoreTb.sv
